//--- include/rv64_consts.svh
// reset PC, register count and bus width constants
`ifndef RV64_CONSTS_SVH
`define RV64_CONSTS_SVH

`define RV64_RESET_PC 32'h0000_0000  // first fetch address

`define RV64_XLEN     64             // data path width
`define RV64_NREGS    32             // architectural registers

`define RV64_ADDR_W   32             // wishbone byte address

`endif

//--- hdl/rv64_pkg.sv
// ALU operation, memory operation, branch kind and core state types
package rv64_pkg;

  typedef enum logic [4:0] {
    ALU_ADD     = 5'b00000,
    ALU_SLL     = 5'b00001,
    ALU_COPYIMM = 5'b00011,
    ALU_XOR     = 5'b00100,
    ALU_SRL     = 5'b00101,
    ALU_OR      = 5'b00110,
    ALU_AND     = 5'b00111,
    ALU_SUB     = 5'b01000,
    ALU_SLTU    = 5'b01010,
    ALU_SRA     = 5'b01101,
    ALU_MUL     = 5'b11100,  // signed, low 64 bits
    ALU_EBREAK  = 5'b11110,
    ALU_INVALID = 5'b11111
  } alu_op_e;

  typedef enum logic [2:0] {
    MEM_SB, MEM_UB, MEM_SH, MEM_UH, MEM_SW, MEM_UW, MEM_SD, MEM_NONE
  } mem_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_JAL  = 3'd1,
    BR_JALR = 3'd2,
    BR_EQ   = 3'd4,
    BR_NE   = 3'd5,
    BR_LT   = 3'd6,  // also bltu
    BR_GE   = 3'd7   // also bgeu
  } branch_e;

  typedef enum logic [1:0] {
    ST_FETCH, ST_EXEC, ST_MEM, ST_HALT
  } core_state_e;

endpackage

//--- hdl/rv64_idu.sv
// instruction decoder: immediate, register indices and control signals
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_idu (
  input  logic [31:0]                i_inst,
  output logic [`RV64_XLEN-1:0]      o_imm,
  output logic [4:0]                 o_ra,
  output logic [4:0]                 o_rb,
  output logic [4:0]                 o_rd,
  output rv64_pkg::branch_e          o_branch,
  output logic                       o_br_unsigned,
  output logic                       o_alu_a_pc,
  output logic [1:0]                 o_alu_b_src,
  output rv64_pkg::alu_op_e          o_alu_op,
  output logic                       o_word_cut,
  output logic                       o_reg_wr,
  output logic                       o_mem_to_reg,
  output logic                       o_mem_wr,
  output rv64_pkg::mem_op_e          o_mem_op,
  output logic                       o_illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] inst_type;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  logic op_load, op_store, op_imm, op_immw, op_reg, op_regw, op_br;
  assign op_load  = (opcode == 7'b0000011);
  assign op_store = (opcode == 7'b0100011);
  assign op_imm   = (opcode == 7'b0010011);
  assign op_immw  = (opcode == 7'b0011011);
  assign op_reg   = (opcode == 7'b0110011);
  assign op_regw  = (opcode == 7'b0111011);
  assign op_br    = (opcode == 7'b1100011);

  logic inst_lui, inst_auipc, inst_jal, inst_jalr, inst_ebreak;
  assign inst_lui    = (opcode == 7'b0110111);
  assign inst_auipc  = (opcode == 7'b0010111);
  assign inst_jal    = (opcode == 7'b1101111);
  assign inst_jalr   = (opcode == 7'b1100111) & (funct3 == 3'b000);
  assign inst_ebreak = (i_inst == 32'h0010_0073);

  logic inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu;
  assign inst_beq  = op_br & (funct3 == 3'b000);
  assign inst_bne  = op_br & (funct3 == 3'b001);
  assign inst_blt  = op_br & (funct3 == 3'b100);
  assign inst_bge  = op_br & (funct3 == 3'b101);
  assign inst_bltu = op_br & (funct3 == 3'b110);
  assign inst_bgeu = op_br & (funct3 == 3'b111);

  logic inst_lh, inst_lhu, inst_lw, inst_lbu, inst_ld;
  logic inst_sb, inst_sh, inst_sw, inst_sd;
  assign inst_lh  = op_load & (funct3 == 3'b001);
  assign inst_lhu = op_load & (funct3 == 3'b101);
  assign inst_lw  = op_load & (funct3 == 3'b010);
  assign inst_lbu = op_load & (funct3 == 3'b100);
  assign inst_ld  = op_load & (funct3 == 3'b011);
  assign inst_sb  = op_store & (funct3 == 3'b000);
  assign inst_sh  = op_store & (funct3 == 3'b001);
  assign inst_sw  = op_store & (funct3 == 3'b010);
  assign inst_sd  = op_store & (funct3 == 3'b011);

  logic inst_addi, inst_sltiu, inst_xori, inst_andi;
  logic inst_slli, inst_srli, inst_srai, inst_addiw;
  assign inst_addi  = op_imm & (funct3 == 3'b000);
  assign inst_sltiu = op_imm & (funct3 == 3'b011);
  assign inst_xori  = op_imm & (funct3 == 3'b100);
  assign inst_andi  = op_imm & (funct3 == 3'b111);
  assign inst_slli  = op_imm & (funct3 == 3'b001) & (funct7[6:1] == 6'b000000);
  assign inst_srli  = op_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b000000);
  assign inst_srai  = op_imm & (funct3 == 3'b101) & (funct7[6:1] == 6'b010000);
  assign inst_addiw = op_immw & (funct3 == 3'b000);

  logic inst_add, inst_sub, inst_or, inst_mul;
  logic inst_addw, inst_subw, inst_sllw, inst_mulw;
  assign inst_add  = op_reg & (funct3 == 3'b000) & (funct7 == 7'b0000000);
  assign inst_sub  = op_reg & (funct3 == 3'b000) & (funct7 == 7'b0100000);
  assign inst_or   = op_reg & (funct3 == 3'b110) & (funct7 == 7'b0000000);
  assign inst_mul  = op_reg & (funct3 == 3'b000) & (funct7 == 7'b0000001);
  assign inst_addw = op_regw & (funct3 == 3'b000) & (funct7 == 7'b0000000);
  assign inst_subw = op_regw & (funct3 == 3'b000) & (funct7 == 7'b0100000);
  assign inst_sllw = op_regw & (funct3 == 3'b001) & (funct7 == 7'b0000000);
  assign inst_mulw = op_regw & (funct3 == 3'b000) & (funct7 == 7'b0000001);

  logic inst_load, inst_store, type_r, type_i, type_u, type_s, type_b, type_j;
  assign inst_load  = |{inst_lh, inst_lhu, inst_lw, inst_lbu, inst_ld};
  assign inst_store = |{inst_sb, inst_sh, inst_sw, inst_sd};
  assign type_r = |{inst_add, inst_sub, inst_or, inst_mul,
                    inst_addw, inst_subw, inst_sllw, inst_mulw};
  assign type_i = |{inst_jalr, inst_load, inst_addi, inst_sltiu, inst_xori, inst_andi,
                    inst_slli, inst_srli, inst_srai, inst_addiw, inst_ebreak};
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_store;
  assign type_b = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};
  assign type_j = inst_jal;
  assign inst_type = {type_r, type_i, type_u, type_s, type_b, type_j};

  always_comb begin
    if (type_u)      o_imm = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
    else if (type_s) o_imm = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    else if (type_b) o_imm = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    else if (type_j) o_imm = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    else             o_imm = {{52{i_inst[31]}}, i_inst[31:20]};  // I type and default
  end

  assign o_illegal     = ~|inst_type;
  assign o_word_cut    = |{inst_addiw, inst_addw, inst_subw, inst_sllw, inst_mulw};
  assign o_reg_wr      = |{type_r, type_i, type_u, type_j};
  assign o_mem_to_reg  = inst_load;
  assign o_mem_wr      = type_s;
  assign o_alu_a_pc    = |{inst_jal, inst_auipc, inst_jalr};
  assign o_alu_b_src   = {inst_jal | inst_jalr, (type_i | type_u | type_s) & ~inst_jalr};
  assign o_br_unsigned = inst_bltu | inst_bgeu;

  always_comb begin
    if (inst_sb)       o_mem_op = rv64_pkg::MEM_SB;
    else if (inst_lbu) o_mem_op = rv64_pkg::MEM_UB;
    else if (inst_lh | inst_sh) o_mem_op = rv64_pkg::MEM_SH;
    else if (inst_lhu) o_mem_op = rv64_pkg::MEM_UH;
    else if (inst_lw | inst_sw) o_mem_op = rv64_pkg::MEM_SW;
    else if (inst_ld | inst_sd) o_mem_op = rv64_pkg::MEM_SD;
    else               o_mem_op = rv64_pkg::MEM_NONE;
  end

  always_comb begin
    if (inst_lui) o_alu_op = rv64_pkg::ALU_COPYIMM;
    else if (|{inst_auipc, inst_jal, inst_jalr, inst_addi, inst_add,
               inst_load, inst_store, inst_addiw, inst_addw})
      o_alu_op = rv64_pkg::ALU_ADD;
    else if (type_b | inst_sub | inst_subw) o_alu_op = rv64_pkg::ALU_SUB;
    else if (inst_sltiu)              o_alu_op = rv64_pkg::ALU_SLTU;
    else if (inst_xori)               o_alu_op = rv64_pkg::ALU_XOR;
    else if (inst_andi)               o_alu_op = rv64_pkg::ALU_AND;
    else if (inst_or)                 o_alu_op = rv64_pkg::ALU_OR;
    else if (inst_slli | inst_sllw)   o_alu_op = rv64_pkg::ALU_SLL;
    else if (inst_srli)               o_alu_op = rv64_pkg::ALU_SRL;
    else if (inst_srai)               o_alu_op = rv64_pkg::ALU_SRA;
    else if (inst_mul | inst_mulw)    o_alu_op = rv64_pkg::ALU_MUL;
    else if (inst_ebreak)             o_alu_op = rv64_pkg::ALU_EBREAK;
    else                              o_alu_op = rv64_pkg::ALU_INVALID;
  end

  always_comb begin
    if (inst_jal)               o_branch = rv64_pkg::BR_JAL;
    else if (inst_jalr)         o_branch = rv64_pkg::BR_JALR;
    else if (inst_beq)          o_branch = rv64_pkg::BR_EQ;
    else if (inst_bne)          o_branch = rv64_pkg::BR_NE;
    else if (inst_blt | inst_bltu) o_branch = rv64_pkg::BR_LT;
    else if (inst_bge | inst_bgeu) o_branch = rv64_pkg::BR_GE;
    else                        o_branch = rv64_pkg::BR_NONE;
  end

  // overlapping groups would pick the wrong immediate
  a_one_group: assert property (@(i_inst) $onehot0(inst_type));

endmodule

//--- hdl/rv64_regfile.sv
// 32 x 64 register file, x0 tied to zero
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_regfile (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [4:0]            i_ra,
  input  logic [4:0]            i_rb,
  input  logic [4:0]            i_rd,
  input  logic                  i_we,
  input  logic [`RV64_XLEN-1:0] i_wdata,
  output logic [`RV64_XLEN-1:0] o_rdata_a,
  output logic [`RV64_XLEN-1:0] o_rdata_b
);

  logic [`RV64_XLEN-1:0] regs [`RV64_NREGS];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `RV64_NREGS; i++) regs[i] <= '0;
    end else if (i_we && (i_rd != 5'd0)) begin  // x0 never written
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rdata_a = regs[i_ra];
  assign o_rdata_b = regs[i_rb];

  a_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ra == 5'd0) |-> (o_rdata_a == '0));

endmodule

//--- hdl/rv64_alu.sv
// 64-bit ALU with word mode and branch compare
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_alu (
  input  logic [`RV64_XLEN-1:0] i_a,
  input  logic [`RV64_XLEN-1:0] i_b,
  input  rv64_pkg::alu_op_e     i_op,
  input  logic                  i_word_cut,
  input  logic                  i_br_unsigned,
  output logic [`RV64_XLEN-1:0] o_result,
  output logic                  o_lt,
  output logic                  o_eq
);

  logic [5:0]            shamt;
  logic [`RV64_XLEN-1:0] a_sh;
  logic [`RV64_XLEN-1:0] raw;

  assign shamt = i_word_cut ? {1'b0, i_b[4:0]} : i_b[5:0];

  always_comb begin
    a_sh = i_a;
    if (i_word_cut) begin  // right shifts only see the low word
      if (i_op == rv64_pkg::ALU_SRA) a_sh = {{32{i_a[31]}}, i_a[31:0]};
      else                           a_sh = {32'b0, i_a[31:0]};
    end
  end

  always_comb begin
    case (i_op)
      rv64_pkg::ALU_COPYIMM: raw = i_b;
      rv64_pkg::ALU_ADD:     raw = i_a + i_b;
      rv64_pkg::ALU_SUB:     raw = i_a - i_b;
      rv64_pkg::ALU_SLTU:    raw = {63'b0, i_a < i_b};
      rv64_pkg::ALU_XOR:     raw = i_a ^ i_b;
      rv64_pkg::ALU_AND:     raw = i_a & i_b;
      rv64_pkg::ALU_OR:      raw = i_a | i_b;
      rv64_pkg::ALU_SLL:     raw = i_a << shamt;
      rv64_pkg::ALU_SRL:     raw = a_sh >> shamt;
      rv64_pkg::ALU_SRA:     raw = $signed(a_sh) >>> shamt;
      rv64_pkg::ALU_MUL:     raw = i_a * i_b;  // low half, sign does not matter
      default:               raw = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  assign o_eq = (i_a == i_b);
  assign o_lt = i_br_unsigned ? (i_a < i_b) : ($signed(i_a) < $signed(i_b));

endmodule

//--- hdl/rv64_mem_if.sv
// wishbone classic master: lane steering, byte select and load extension
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_mem_if (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_req,
  input  logic                    i_we,
  input  logic [`RV64_ADDR_W-1:0] i_addr,
  input  rv64_pkg::mem_op_e       i_mem_op,
  input  logic [`RV64_XLEN-1:0]   i_wdata,
  output logic                    o_done,
  output logic [`RV64_XLEN-1:0]   o_rdata,
  output logic                    o_wb_cyc,
  output logic                    o_wb_stb,
  output logic                    o_wb_we,
  output logic [`RV64_ADDR_W-1:0] o_wb_adr,
  output logic [7:0]              o_wb_sel,
  output logic [`RV64_XLEN-1:0]   o_wb_dat,
  input  logic [`RV64_XLEN-1:0]   i_wb_dat,
  input  logic                    i_wb_ack
);

  logic [2:0]            off;
  logic [`RV64_XLEN-1:0] lane;

  assign off      = i_addr[2:0];
  assign o_wb_cyc = i_req;
  assign o_wb_stb = i_req;
  assign o_wb_we  = i_req & i_we;
  assign o_wb_adr = {i_addr[`RV64_ADDR_W-1:3], 3'b000};  // doubleword aligned
  assign o_done   = i_wb_ack;
  assign lane     = i_wb_dat >> {off, 3'b000};

  always_comb begin
    case (i_mem_op)
      rv64_pkg::MEM_SB, rv64_pkg::MEM_UB: begin
        o_wb_sel = 8'b0000_0001 << off;
        o_wb_dat = {8{i_wdata[7:0]}};
      end
      rv64_pkg::MEM_SH, rv64_pkg::MEM_UH: begin
        o_wb_sel = 8'b0000_0011 << off;
        o_wb_dat = {4{i_wdata[15:0]}};
      end
      rv64_pkg::MEM_SW, rv64_pkg::MEM_UW: begin
        o_wb_sel = 8'b0000_1111 << off;
        o_wb_dat = {2{i_wdata[31:0]}};
      end
      rv64_pkg::MEM_SD: begin
        o_wb_sel = 8'hff;
        o_wb_dat = i_wdata;
      end
      default: begin
        o_wb_sel = 8'h00;
        o_wb_dat = i_wdata;
      end
    endcase
  end

  always_comb begin
    case (i_mem_op)
      rv64_pkg::MEM_SB: o_rdata = {{56{lane[7]}}, lane[7:0]};
      rv64_pkg::MEM_UB: o_rdata = {56'b0, lane[7:0]};
      rv64_pkg::MEM_SH: o_rdata = {{48{lane[15]}}, lane[15:0]};
      rv64_pkg::MEM_UH: o_rdata = {48'b0, lane[15:0]};
      rv64_pkg::MEM_SW: o_rdata = {{32{lane[31]}}, lane[31:0]};
      rv64_pkg::MEM_UW: o_rdata = {32'b0, lane[31:0]};  // fetch path
      default:          o_rdata = lane;
    endcase
  end

  a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_stb |-> o_wb_cyc);

  a_adr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_wb_cyc && !i_wb_ack) |=> (o_wb_cyc && $stable(o_wb_adr)));

endmodule

//--- hdl/rv64_core.sv
// core top: PC, instruction register, FSM and datapath instances
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_core (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  output logic                    o_wb_cyc,
  output logic                    o_wb_stb,
  output logic                    o_wb_we,
  output logic [`RV64_ADDR_W-1:0] o_wb_adr,
  output logic [7:0]              o_wb_sel,
  output logic [`RV64_XLEN-1:0]   o_wb_dat,
  input  logic [`RV64_XLEN-1:0]   i_wb_dat,
  input  logic                    i_wb_ack,
  output logic                    o_halt,
  output logic                    o_illegal
);

  rv64_pkg::core_state_e state;
  logic [`RV64_XLEN-1:0] pc;
  logic [31:0]           ir;
  logic                  bus_gap;  // one idle cycle after each ack

  logic [`RV64_XLEN-1:0] imm, rs1, rs2, alu_a, alu_b, alu_res, mem_rdata;
  logic [4:0]            ra, rb, rd;
  rv64_pkg::branch_e     branch;
  rv64_pkg::alu_op_e     alu_op;
  rv64_pkg::mem_op_e     mem_op, bus_op;
  logic br_unsigned, alu_a_pc, word_cut, reg_wr, mem_to_reg, mem_wr, illegal;
  logic [1:0]            alu_b_src;
  logic alu_lt, alu_eq, taken, stop, bus_req, done, rf_we;
  logic [`RV64_XLEN-1:0] pc_plus4, next_pc;

  rv64_idu idu_i (
    .i_inst(ir), .o_imm(imm), .o_ra(ra), .o_rb(rb), .o_rd(rd),
    .o_branch(branch), .o_br_unsigned(br_unsigned), .o_alu_a_pc(alu_a_pc),
    .o_alu_b_src(alu_b_src), .o_alu_op(alu_op), .o_word_cut(word_cut),
    .o_reg_wr(reg_wr), .o_mem_to_reg(mem_to_reg), .o_mem_wr(mem_wr),
    .o_mem_op(mem_op), .o_illegal(illegal)
  );

  assign stop  = illegal | (alu_op == rv64_pkg::ALU_EBREAK);
  assign rf_we = ((state == rv64_pkg::ST_EXEC) & reg_wr & ~mem_to_reg & ~stop) |
                 ((state == rv64_pkg::ST_MEM) & mem_to_reg & done);

  rv64_regfile regfile_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ra(ra), .i_rb(rb), .i_rd(rd), .i_we(rf_we),
    .i_wdata((state == rv64_pkg::ST_MEM) ? mem_rdata : alu_res),
    .o_rdata_a(rs1), .o_rdata_b(rs2)
  );

  assign alu_a = alu_a_pc ? pc : rs1;
  always_comb begin
    case (alu_b_src)
      2'b01:   alu_b = imm;
      2'b10:   alu_b = 64'd4;  // link value
      default: alu_b = rs2;
    endcase
  end

  rv64_alu alu_i (
    .i_a(alu_a), .i_b(alu_b), .i_op(alu_op), .i_word_cut(word_cut),
    .i_br_unsigned(br_unsigned), .o_result(alu_res), .o_lt(alu_lt), .o_eq(alu_eq)
  );

  assign bus_req = ((state == rv64_pkg::ST_FETCH) | (state == rv64_pkg::ST_MEM)) & ~bus_gap;
  always_comb begin
    if (state == rv64_pkg::ST_FETCH) bus_op = rv64_pkg::MEM_UW;
    else                             bus_op = mem_op;
  end

  rv64_mem_if mem_if_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(bus_req),
    .i_we((state == rv64_pkg::ST_MEM) & mem_wr),
    .i_addr((state == rv64_pkg::ST_FETCH) ? pc[`RV64_ADDR_W-1:0]
                                          : alu_res[`RV64_ADDR_W-1:0]),
    .i_mem_op(bus_op), .i_wdata(rs2), .o_done(done), .o_rdata(mem_rdata),
    .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_we(o_wb_we), .o_wb_adr(o_wb_adr),
    .o_wb_sel(o_wb_sel), .o_wb_dat(o_wb_dat), .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack)
  );

  always_comb begin
    case (branch)
      rv64_pkg::BR_JAL, rv64_pkg::BR_JALR: taken = 1'b1;
      rv64_pkg::BR_EQ: taken = alu_eq;
      rv64_pkg::BR_NE: taken = ~alu_eq;
      rv64_pkg::BR_LT: taken = alu_lt;
      rv64_pkg::BR_GE: taken = ~alu_lt;
      default:         taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + 64'd4;
  assign next_pc  = (branch == rv64_pkg::BR_JALR) ? ((rs1 + imm) & ~64'd1) :
                    taken ? (pc + imm) : pc_plus4;

  always_ff @(posedge i_clk) begin
    if (state == rv64_pkg::ST_FETCH && done) ir <= mem_rdata[31:0];
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state     <= rv64_pkg::ST_FETCH;
      pc        <= `RV64_XLEN'(`RV64_RESET_PC);
      bus_gap   <= 1'b1;
      o_halt    <= 1'b0;
      o_illegal <= 1'b0;
    end else begin
      bus_gap <= done;
      case (state)
        rv64_pkg::ST_FETCH: if (done) state <= rv64_pkg::ST_EXEC;
        rv64_pkg::ST_EXEC: begin
          if (stop) begin
            state     <= rv64_pkg::ST_HALT;
            o_halt    <= 1'b1;
            o_illegal <= illegal;
          end else if (mem_to_reg | mem_wr) begin
            state <= rv64_pkg::ST_MEM;
          end else begin
            state <= rv64_pkg::ST_FETCH;
            pc    <= next_pc;
          end
        end
        rv64_pkg::ST_MEM: begin
          if (done) begin
            state <= rv64_pkg::ST_FETCH;
            pc    <= pc_plus4;
          end
        end
        default: state <= rv64_pkg::ST_HALT;  // stays stopped
      endcase
    end
  end

  a_mem_entry: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (state == rv64_pkg::ST_EXEC && !(mem_to_reg || mem_wr)) |=> (state != rv64_pkg::ST_MEM));

endmodule

//--- bench/rv64_core_tb.sv
// testbench with wishbone memory model, program builder, reference function, checker and watchdog
`timescale 1ns/1ps

module rv64_core_tb;

  localparam int RES_BASE  = 'h400;  // result slots
  localparam int DATA_BASE = 'h600;  // operand words

  logic        clk;
  logic        rst_n;
  logic [63:0] wb_rdat;
  logic        wb_ack;
  logic        wb_cyc, wb_stb, wb_we, halt, illegal;
  logic [31:0] wb_adr;
  logic [7:0]  wb_sel;
  logic [63:0] wb_wdat;

  logic [63:0] mem [512];
  logic [63:0] exp_val [64];
  logic [7:0]  exp_sel [64];
  int          n_res, n_seen, n_data, n_blk, ptr, wcnt;
  logic [31:0] lcg_state;
  bit          built, busy;
  logic        s_cyc, s_stb, s_we, p_cyc, p_ack, p_we;
  logic [31:0] s_adr, p_adr;
  logic [7:0]  s_sel, p_sel;
  logic [63:0] s_dat, p_dat;

  rv64_core dut_i (
    .i_clk(clk), .i_rst_n(rst_n), .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we),
    .o_wb_adr(wb_adr), .o_wb_sel(wb_sel), .o_wb_dat(wb_wdat), .i_wb_dat(wb_rdat),
    .i_wb_ack(wb_ack), .o_halt(halt), .o_illegal(illegal)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] sext32(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  // expected value of one ALU type instruction
  function automatic logic [63:0] ref_calc(input string op, input logic [63:0] a,
                                           input logic [63:0] b, input logic [63:0] imm,
                                           input logic [63:0] pc);
    case (op)
      "add":   return a + b;
      "sub":   return a - b;
      "or":    return a | b;
      "mul":   return a * b;
      "addw":  return sext32(a + b);
      "subw":  return sext32(a - b);
      "sllw":  return sext32({32'b0, a[31:0] << b[4:0]});
      "mulw":  return sext32({32'b0, a[31:0] * b[31:0]});
      "addi":  return a + imm;
      "sltiu": return {63'b0, a < imm};
      "xori":  return a ^ imm;
      "andi":  return a & imm;
      "slli":  return a << imm[5:0];
      "srli":  return a >> imm[5:0];
      "srai":  return $signed(a) >>> imm[5:0];
      "addiw": return sext32(a + imm);
      "lui":   return imm;
      "auipc": return pc + imm;
      default: return 64'hx;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic emit(input logic [31:0] w);
    if (ptr[2]) mem[ptr >> 3][63:32] = w;
    else        mem[ptr >> 3][31:0]  = w;
    ptr += 4;
  endtask

  task automatic new_data(output int off, output logic [63:0] v);
    v = {lcg_next(), lcg_next()};
    off = DATA_BASE + 8 * n_data;
    mem[off >> 3] = v;
    n_data++;
  endtask

  task automatic new_slot(input logic [63:0] v, input logic [7:0] sel, output int off);
    exp_val[n_res] = v;
    exp_sel[n_res] = sel;
    off = RES_BASE + 8 * n_res;
    n_res++;
  endtask

  task automatic r_block(input string op, input logic [6:0] f7, input logic [2:0] f3,
                         input logic [6:0] opc);
    int da, db, r;
    logic [63:0] a, b;
    new_data(da, a);
    new_data(db, b);
    emit(enc_i(da, 0, 3'd3, 1, 7'h03));
    emit(enc_i(db, 0, 3'd3, 2, 7'h03));
    emit(enc_r(f7, 2, 1, f3, 3, opc));
    new_slot(ref_calc(op, a, b, 0, 0), 8'hff, r);
    emit(enc_s(r, 3, 0, 3'd3));
    n_blk++;
  endtask

  task automatic i_block(input string op, input logic [2:0] f3, input logic [6:0] opc,
                         input logic [11:0] imm);
    int da, r;
    logic [63:0] a;
    new_data(da, a);
    emit(enc_i(da, 0, 3'd3, 1, 7'h03));
    emit(enc_i(imm, 1, f3, 3, opc));
    new_slot(ref_calc(op, a, 0, {{52{imm[11]}}, imm}, 0), 8'hff, r);
    emit(enc_s(r, 3, 0, 3'd3));
    n_blk++;
  endtask

  task automatic u_block(input string op, input logic [6:0] opc, input logic [19:0] imm);
    int r;
    new_slot(ref_calc(op, 0, 0, {{32{imm[19]}}, imm, 12'b0}, ptr), 8'hff, r);
    emit({imm, 5'd3, opc});
    emit(enc_s(r, 3, 0, 3'd3));
    n_blk++;
  endtask

  task automatic load_block(input logic [2:0] f3, input int off);
    int da, r;
    logic [63:0] d, lane, e;
    new_data(da, d);
    lane = d >> (8 * off);
    case (f3)
      3'd1:    e = {{48{lane[15]}}, lane[15:0]};
      3'd2:    e = sext32(lane);
      3'd4:    e = {56'b0, lane[7:0]};
      3'd5:    e = {48'b0, lane[15:0]};
      default: e = lane;
    endcase
    emit(enc_i(da + off, 0, f3, 3, 7'h03));
    new_slot(e, 8'hff, r);
    emit(enc_s(r, 3, 0, 3'd3));
    n_blk++;
  endtask

  task automatic store_block(input logic [2:0] f3, input int off);
    int da, r;
    logic [63:0] d;
    logic [7:0]  sel;
    new_data(da, d);
    sel = 8'((9'd1 << (1 << f3)) - 9'd1) << off;
    emit(enc_i(da, 0, 3'd3, 2, 7'h03));
    new_slot(d << (8 * off), sel, r);
    emit(enc_s(r + off, 2, 0, f3));
    n_blk++;
  endtask

  // marker 0x33 means the branch skipped the 0x22 write
  task automatic br_block(input logic [2:0] f3, input bit same);
    int da, db, r;
    logic [63:0] a, b;
    bit tk;
    new_data(da, a);
    if (same) begin
      db = da;
      b  = a;
    end else begin
      new_data(db, b);
    end
    case (f3)
      3'd0:    tk = (a == b);
      3'd1:    tk = (a != b);
      3'd4:    tk = ($signed(a) < $signed(b));
      3'd5:    tk = ($signed(a) >= $signed(b));
      3'd6:    tk = (a < b);
      default: tk = (a >= b);
    endcase
    emit(enc_i(da, 0, 3'd3, 1, 7'h03));
    emit(enc_i(db, 0, 3'd3, 2, 7'h03));
    emit(enc_i(12'h033, 0, 3'd0, 3, 7'h13));
    emit(enc_b(13'd8, 2, 1, f3));
    emit(enc_i(12'h022, 0, 3'd0, 3, 7'h13));
    new_slot(tk ? 64'h33 : 64'h22, 8'hff, r);
    emit(enc_s(r, 3, 0, 3'd3));
    n_blk++;
  endtask

  task automatic jump_block(input bit use_jalr);
    int r1, r2, pc_j;
    emit(enc_i(12'h033, 0, 3'd0, 3, 7'h13));
    if (use_jalr) begin
      emit(enc_i(ptr + 12, 0, 3'd0, 6, 7'h13));  // x6 = jalr target
      pc_j = ptr;
      emit(enc_i(12'd1, 6, 3'd0, 4, 7'h67));  // bit 0 cleared
    end else begin
      pc_j = ptr;
      emit(enc_j(21'd8, 4));
    end
    emit(enc_i(12'h022, 0, 3'd0, 3, 7'h13));
    new_slot(64'h33, 8'hff, r1);
    new_slot(pc_j + 4, 8'hff, r2);
    emit(enc_s(r1, 3, 0, 3'd3));
    emit(enc_s(r2, 4, 0, 3'd3));
    n_blk++;
  endtask

  task automatic fail_stop();
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic wait_halt();
    do @(negedge clk); while (!halt);
  endtask

  always @(negedge clk) begin
    s_cyc = wb_cyc;
    s_stb = wb_stb;
    s_we  = wb_we;
    s_adr = wb_adr;
    s_sel = wb_sel;
    s_dat = wb_wdat;
    if (rst_n) begin
      assert (!wb_stb || wb_cyc) else begin
        $display("stb was high without cyc at %0t", $time);
        fail_stop();
      end
      assert (!(p_cyc && !p_ack) ||
              (wb_cyc && wb_adr == p_adr && wb_we == p_we && wb_sel == p_sel &&
               wb_wdat === p_dat)) else begin
        $display("bus cycle dropped or request changed before ack at %0t", $time);
        fail_stop();
      end
      assert (!(p_cyc && p_ack) || !wb_cyc) else begin
        $display("cyc still high in the cycle after ack at %0t", $time);
        fail_stop();
      end
    end
    if (rst_n && wb_ack && wb_cyc && wb_we && wb_adr >= RES_BASE && wb_adr < DATA_BASE)
      check_write((wb_adr - RES_BASE) >> 3);
    p_cyc = wb_cyc && rst_n;
    p_ack = wb_ack;
    p_adr = wb_adr;
    p_we  = wb_we;
    p_sel = wb_sel;
    p_dat = wb_wdat;
  end

  task automatic check_write(input int k);
    logic [63:0] m;
    for (int i = 0; i < 8; i++) m[8*i +: 8] = {8{exp_sel[k][i]}};
    assert (k < n_res) else begin
      $display("write to unused result slot %0d", k);
      fail_stop();
    end
    assert (wb_sel == exp_sel[k]) else begin
      $display("[FAIL] o_wb_sel slot %0d got %h expected %h", k, wb_sel, exp_sel[k]);
      fail_stop();
    end
    assert ((wb_wdat & m) == (exp_val[k] & m)) else begin
      $display("[FAIL] o_wb_dat slot %0d got %h expected %h", k, wb_wdat & m, exp_val[k] & m);
      fail_stop();
    end
    n_seen++;
  endtask

  // wishbone slave with 0 to 3 wait cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
    end else if (s_cyc && s_stb) begin
      if (!busy) begin
        busy = 1'b1;
        wcnt = (lcg_next() >> 16) & 3;
      end
      if (wcnt == 0) begin
        busy = 1'b0;
        wb_ack <= 1'b1;
        if (s_we) begin
          for (int i = 0; i < 8; i++)
            if (s_sel[i]) mem[s_adr[11:3]][8*i +: 8] = s_dat[8*i +: 8];
        end else begin
          wb_rdat <= mem[s_adr[11:3]];
        end
      end else begin
        wcnt--;
      end
    end
  end

  initial begin
    wait (built);
    repeat ((n_blk + 2) * 40 * 4) @(posedge clk);
    $display("timeout: the core did not reach halt in time");
    fail_stop();
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    wb_ack = 1'b0;
    wb_rdat = '0;
    lcg_state = 32'd78153;
    for (int i = 0; i < 512; i++) mem[i] = {32'(i) ^ 32'h5a5a_0000, ~32'(i)};
    r_block("add", 7'h00, 3'd0, 7'h33);
    r_block("sub", 7'h20, 3'd0, 7'h33);
    r_block("or", 7'h00, 3'd6, 7'h33);
    r_block("mul", 7'h01, 3'd0, 7'h33);
    r_block("addw", 7'h00, 3'd0, 7'h3b);
    r_block("subw", 7'h20, 3'd0, 7'h3b);
    r_block("sllw", 7'h00, 3'd1, 7'h3b);
    r_block("mulw", 7'h01, 3'd0, 7'h3b);
    i_block("addi", 3'd0, 7'h13, 12'h9a5);
    i_block("sltiu", 3'd3, 7'h13, 12'hf00);
    i_block("xori", 3'd4, 7'h13, 12'h7c3);
    i_block("andi", 3'd7, 7'h13, 12'h8ff);
    i_block("slli", 3'd1, 7'h13, 12'h027);
    i_block("srli", 3'd5, 7'h13, 12'h03d);
    i_block("srai", 3'd5, 7'h13, 12'h42b);
    i_block("addiw", 3'd0, 7'h1b, 12'h7ff);
    u_block("lui", 7'h37, 20'hbeef1);
    u_block("auipc", 7'h17, 20'h12345);
    load_block(3'd1, 2);
    load_block(3'd1, 6);
    load_block(3'd5, 4);
    load_block(3'd2, 4);
    load_block(3'd2, 0);
    load_block(3'd4, 3);
    load_block(3'd4, 7);
    load_block(3'd3, 0);
    store_block(3'd0, 5);
    store_block(3'd1, 2);
    store_block(3'd2, 4);
    foreach (exp_sel[i]) if (i < 6) br_block(3'(i < 2 ? i : i + 2), 1'b0);
    br_block(3'd0, 1'b1);
    br_block(3'd5, 1'b1);
    jump_block(1'b0);
    jump_block(1'b1);
    emit(32'h0010_0073);  // ebreak
    built = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    wait_halt();
    assert (!illegal) else begin
      $display("o_illegal was set after ebreak");
      fail_stop();
    end
    repeat (20) begin
      @(negedge clk);
      assert (!wb_cyc) else begin
        $display("bus cycle started after halt");
        fail_stop();
      end
    end
    // second run with an undecodable first word
    mem[0][31:0] = 32'hffff_ffff;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    wait_halt();
    if (n_seen == n_res && illegal) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("missing result writes or o_illegal low: %0d of %0d seen", n_seen, n_res);
      fail_stop();
    end
  end

endmodule

//--- rv64_core.f
+incdir+include
hdl/rv64_pkg.sv
hdl/rv64_idu.sv
hdl/rv64_regfile.sv
hdl/rv64_alu.sv
hdl/rv64_mem_if.sv
hdl/rv64_core.sv
bench/rv64_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv64_core_tb --Mdir obj_dir -f rv64_core.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out="$(./obj_dir/Vrv64_core_tb 2>&1)"
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
